// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  localparam int TAG_W          = 20;
  localparam int INDEX_W        = 8;
  localparam int OFFSET_W       = 4;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;

  typedef logic [TAG_W-1:0]                   tag_t;
  typedef logic [INDEX_W-1:0]                 index_t;
  typedef logic [OFFSET_W-1:0]                offset_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]  word_sel_t;  // offset[3:2]
  typedef logic [WORD_W-1:0]                  word_t;
  typedef logic [WORD_W/8-1:0]                strb_t;
  typedef logic [WORDS_PER_LINE*WORD_W-1:0]   line_t;      // word 0 in low bits
  typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0]  addr_t;      // {tag, index, offset}

  // one cpu access
  typedef struct packed {
    logic    op;      // 1 = store
    tag_t    tag;
    index_t  index;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
  } cpu_req_t;

  // tag array entry of one way
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tagv_t;

  typedef enum logic [2:0] {
    state_idle,
    state_lookup,
    state_miss,     // pick victim
    state_replace,  // write back, then ask for the line
    state_refill
  } cache_state_t;

endpackage

`default_nettype wire

// File: design/tagv_array.sv
`timescale 1ns/1ps
`default_nettype none

module tagv_array (
  input  wire logic                clk,
  input  wire logic                resetn,
  input  dcache_pkg::index_t       rd_index,
  input  wire logic                fill_en,
  input  wire logic                fill_way,
  input  dcache_pkg::index_t       wr_index,
  input  dcache_pkg::tag_t         fill_tag,
  input  wire logic                fill_dirty,
  input  wire logic                mark_en,
  input  wire logic                mark_way,
  output dcache_pkg::tagv_t        way0_entry,
  output dcache_pkg::tagv_t        way1_entry
);

  localparam int SETS = 2**dcache_pkg::INDEX_W;

  logic [1:0][SETS-1:0] valid_q;
  logic [1:0][SETS-1:0] dirty_q;
  dcache_pkg::tag_t     tag_mem [2][SETS];

  // valid and dirty per way, all clear after reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_way][wr_index] <= 1'b1;
      dirty_q[fill_way][wr_index] <= fill_dirty;
    end else if (mark_en) begin
      dirty_q[mark_way][wr_index] <= 1'b1;  // store hit
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_mem[fill_way][wr_index] <= fill_tag;
    end
  end

  // registered read, one cycle after rd_index
  always_ff @(posedge clk) begin
    way0_entry.valid <= valid_q[0][rd_index];
    way0_entry.dirty <= dirty_q[0][rd_index];
    way0_entry.tag   <= tag_mem[0][rd_index];
    way1_entry.valid <= valid_q[1][rd_index];
    way1_entry.dirty <= dirty_q[1][rd_index];
    way1_entry.tag   <= tag_mem[1][rd_index];
  end

endmodule

`default_nettype wire

// File: design/data_way.sv
`timescale 1ns/1ps
`default_nettype none

module data_way (
  input  wire logic               clk,
  input  dcache_pkg::index_t      rd_index,
  input  dcache_pkg::index_t      wr_index,
  input  dcache_pkg::strb_t       wr_en,
  input  dcache_pkg::word_sel_t   wr_word,
  input  dcache_pkg::word_t       wr_wdata,
  output dcache_pkg::line_t       line
);

  localparam int SETS  = 2**dcache_pkg::INDEX_W;
  localparam int BANKS = dcache_pkg::WORDS_PER_LINE;
  localparam int BYTES = dcache_pkg::WORD_W / 8;

  // one bank per word of the line
  dcache_pkg::word_t bank [BANKS][SETS];

  always_ff @(posedge clk) begin
    for (int b = 0; b < BYTES; b++) begin
      if (wr_en[b]) begin
        bank[wr_word][wr_index][8*b +: 8] <= wr_wdata[8*b +: 8];
      end
    end
  end

  // whole line comes back a cycle later
  always_ff @(posedge clk) begin
    for (int w = 0; w < BANKS; w++) begin
      line[w*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] <= bank[w][rd_index];
    end
  end

endmodule

`default_nettype wire

// File: design/victim_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module victim_lfsr #(
  parameter logic [7:0] SEED = 8'h59  // must be nonzero
) (
  input  wire logic clk,
  input  wire logic resetn,
  output wire logic victim_bit
);

  logic [7:0] lfsr_q;

  // fibonacci form, taps 7 5 3 2
  always_ff @(posedge clk) begin
    if (!resetn) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  assign victim_bit = lfsr_q[7];

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire logic               clk,
  input  wire logic               resetn,
  input  wire logic               valid,
  input  dcache_pkg::cpu_req_t    req,
  input  wire logic               rd_rdy,
  input  wire logic               ret_valid,
  input  wire logic               ret_last,
  input  dcache_pkg::word_t       ret_data,
  input  wire logic               wr_rdy,
  input  dcache_pkg::tagv_t       way0_entry,
  input  dcache_pkg::tagv_t       way1_entry,
  input  dcache_pkg::line_t       way0_line,
  input  dcache_pkg::line_t       way1_line,
  input  wire logic               victim_bit,
  output logic                    addr_ok,
  output logic                    data_ok,
  output dcache_pkg::word_t       rdata,
  output logic                    rd_req,
  output dcache_pkg::addr_t       rd_addr,
  output logic                    wr_req,
  output dcache_pkg::addr_t       wr_addr,
  output dcache_pkg::line_t       wr_data,
  output dcache_pkg::index_t      rd_index,
  output logic                    fill_en,
  output logic                    fill_way,
  output dcache_pkg::tag_t        fill_tag,
  output logic                    fill_dirty,
  output logic                    mark_en,
  output logic                    mark_way,
  output dcache_pkg::index_t      wr_index,
  output dcache_pkg::strb_t       way0_wr_en,
  output dcache_pkg::strb_t       way1_wr_en,
  output dcache_pkg::word_sel_t   wr_word,
  output dcache_pkg::word_t       wr_wdata
);

  localparam int WW = dcache_pkg::WORD_W;

  dcache_pkg::cache_state_t state;
  dcache_pkg::cpu_req_t     req_r;          // request buffer
  dcache_pkg::word_sel_t    req_word;
  dcache_pkg::word_sel_t    beat_cnt;
  dcache_pkg::tagv_t        victim_entry;
  dcache_pkg::line_t        hit_line;
  dcache_pkg::word_t        merged_word;
  dcache_pkg::word_t        refill_word;
  logic                     victim_way_r;
  logic                     wb_pending;
  logic                     way0_hit;
  logic                     way1_hit;
  logic                     cache_hit;
  logic                     victim_sel;
  logic                     lookup_store;
  logic                     refill_beat;

  assign req_word  = req_r.offset[dcache_pkg::OFFSET_W-1 -: 2];
  assign way0_hit  = way0_entry.valid && (way0_entry.tag == req_r.tag);
  assign way1_hit  = way1_entry.valid && (way1_entry.tag == req_r.tag);
  assign cache_hit = way0_hit || way1_hit;

  // fill an empty way first, otherwise random
  assign victim_sel   = !way0_entry.valid ? 1'b0 :
                        !way1_entry.valid ? 1'b1 : victim_bit;
  assign victim_entry = victim_way_r ? way1_entry : way0_entry;

  always_ff @(posedge clk) begin
    if (valid && addr_ok) begin
      req_r <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= dcache_pkg::state_idle;
      victim_way_r <= 1'b0;
      wb_pending   <= 1'b0;
      beat_cnt     <= '0;
    end else begin
      case (state)
        dcache_pkg::state_idle: begin
          if (valid) state <= dcache_pkg::state_lookup;
        end
        dcache_pkg::state_lookup: begin
          state <= cache_hit ? dcache_pkg::state_idle : dcache_pkg::state_miss;
        end
        dcache_pkg::state_miss: begin
          victim_way_r <= victim_sel;
          wb_pending   <= victim_sel ? (way1_entry.valid && way1_entry.dirty)
                                     : (way0_entry.valid && way0_entry.dirty);
          state        <= dcache_pkg::state_replace;
        end
        dcache_pkg::state_replace: begin
          if (wb_pending) begin
            if (wr_rdy) wb_pending <= 1'b0;  // line write done
          end else if (rd_rdy) begin
            beat_cnt <= '0;
            state    <= dcache_pkg::state_refill;
          end
        end
        dcache_pkg::state_refill: begin
          if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (ret_last) state <= dcache_pkg::state_idle;
          end
        end
        default: state <= dcache_pkg::state_idle;
      endcase
    end
  end

  // store bytes over the returned word
  always_comb begin
    for (int b = 0; b < WW/8; b++) begin
      merged_word[8*b +: 8] = req_r.wstrb[b] ? req_r.wdata[8*b +: 8] : ret_data[8*b +: 8];
    end
  end

  assign refill_beat  = (state == dcache_pkg::state_refill) && ret_valid;
  assign refill_word  = (req_r.op && beat_cnt == req_word) ? merged_word : ret_data;
  assign lookup_store = (state == dcache_pkg::state_lookup) && req_r.op && cache_hit;

  assign addr_ok  = (state == dcache_pkg::state_idle);
  assign data_ok  = ((state == dcache_pkg::state_lookup) && cache_hit) ||
                    (refill_beat && (req_r.op ? ret_last : beat_cnt == req_word));
  assign hit_line = way1_hit ? way1_line : way0_line;
  assign rdata    = (state == dcache_pkg::state_lookup) ? hit_line[req_word*WW +: WW]
                                                        : ret_data;  // early return

  assign wr_req  = (state == dcache_pkg::state_replace) && wb_pending;
  assign wr_addr = {victim_entry.tag, req_r.index, dcache_pkg::offset_t'(0)};
  assign wr_data = victim_way_r ? way1_line : way0_line;
  assign rd_req  = (state == dcache_pkg::state_replace) && !wb_pending;
  assign rd_addr = {req_r.tag, req_r.index, dcache_pkg::offset_t'(0)};

  assign rd_index   = addr_ok ? req.index : req_r.index;
  assign wr_index   = req_r.index;
  assign fill_en    = refill_beat && ret_last;
  assign fill_way   = victim_way_r;
  assign fill_tag   = req_r.tag;
  assign fill_dirty = req_r.op;
  assign mark_en    = lookup_store;
  assign mark_way   = way1_hit;

  assign way0_wr_en = (lookup_store && way0_hit)      ? req_r.wstrb :
                      (refill_beat && !victim_way_r)  ? '1 : '0;
  assign way1_wr_en = (lookup_store && way1_hit)      ? req_r.wstrb :
                      (refill_beat && victim_way_r)   ? '1 : '0;
  assign wr_word    = (state == dcache_pkg::state_refill) ? beat_cnt : req_word;
  assign wr_wdata   = (state == dcache_pkg::state_refill) ? refill_word : req_r.wdata;

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter logic [7:0] LFSR_SEED = 8'h59
) (
  input  wire logic             clk,
  input  wire logic             resetn,
  input  wire logic             valid,
  input  dcache_pkg::cpu_req_t  req,
  output logic                  addr_ok,
  output logic                  data_ok,
  output dcache_pkg::word_t     rdata,
  output logic                  rd_req,
  output dcache_pkg::addr_t     rd_addr,
  input  wire logic             rd_rdy,
  input  wire logic             ret_valid,
  input  wire logic             ret_last,
  input  dcache_pkg::word_t     ret_data,
  output logic                  wr_req,
  output dcache_pkg::addr_t     wr_addr,
  output dcache_pkg::line_t     wr_data,
  input  wire logic             wr_rdy
);

  dcache_pkg::tagv_t     way0_entry;
  dcache_pkg::tagv_t     way1_entry;
  dcache_pkg::line_t     way0_line;
  dcache_pkg::line_t     way1_line;
  dcache_pkg::index_t    rd_index;
  dcache_pkg::index_t    wr_index;
  dcache_pkg::tag_t      fill_tag;
  dcache_pkg::strb_t     way0_wr_en;
  dcache_pkg::strb_t     way1_wr_en;
  dcache_pkg::word_sel_t wr_word;
  dcache_pkg::word_t     wr_wdata;
  logic                  fill_en;
  logic                  fill_way;
  logic                  fill_dirty;
  logic                  mark_en;
  logic                  mark_way;
  logic                  victim_bit;

  cache_ctrl ctrl_inst (
    .clk, .resetn, .valid, .req, .rd_rdy, .ret_valid, .ret_last, .ret_data, .wr_rdy,
    .way0_entry, .way1_entry, .way0_line, .way1_line, .victim_bit,
    .addr_ok, .data_ok, .rdata, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data,
    .rd_index, .fill_en, .fill_way, .fill_tag, .fill_dirty, .mark_en, .mark_way,
    .wr_index, .way0_wr_en, .way1_wr_en, .wr_word, .wr_wdata
  );

  tagv_array tagv_inst (
    .clk, .resetn, .rd_index, .fill_en, .fill_way, .wr_index, .fill_tag,
    .fill_dirty, .mark_en, .mark_way, .way0_entry, .way1_entry
  );

  data_way way0_inst (
    .clk, .rd_index, .wr_index, .wr_en(way0_wr_en), .wr_word, .wr_wdata, .line(way0_line)
  );

  data_way way1_inst (
    .clk, .rd_index, .wr_index, .wr_en(way1_wr_en), .wr_word, .wr_wdata, .line(way1_line)
  );

  victim_lfsr #(.SEED(LFSR_SEED)) lfsr_inst (
    .clk, .resetn, .victim_bit
  );

endmodule

`default_nettype wire

// File: dv/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  wire logic             clk,
  input  wire logic             rd_req,
  input  dcache_pkg::addr_t     rd_addr,
  output logic                  rd_rdy,
  output logic                  ret_valid,
  output logic                  ret_last,
  output dcache_pkg::word_t     ret_data,
  input  wire logic             wr_req,
  input  dcache_pkg::addr_t     wr_addr,
  input  dcache_pkg::line_t     wr_data,
  output logic                  wr_rdy
);

  dcache_pkg::word_t mem [4096];  // 16 KB, enough for tags 0 to 3
  dcache_pkg::line_t wb_line;
  int                base;

  // wait 0 to 3 cycles, staying 5 ns past the edge
  task automatic stall();
    repeat ($urandom % 4) begin
      @(posedge clk);
      #5;
    end
  endtask

  initial begin
    rd_rdy    = 1'b0;
    wr_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret_last  = 1'b0;
    ret_data  = '0;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = (i * 4) ^ 32'hA5A5_0000;  // byte address xor pattern
    end
    forever begin
      @(posedge clk);
      #5;
      if (wr_req) begin
        stall();
        wr_rdy  = 1'b1;
        base    = int'(wr_addr[13:2]);
        wb_line = wr_data;  // held by the cache until accepted
        @(posedge clk);
        #5;
        wr_rdy = 1'b0;
        for (int w = 0; w < 4; w++) begin
          mem[base + w] = wb_line[32*w +: 32];
        end
      end else if (rd_req) begin
        stall();
        rd_rdy = 1'b1;
        base   = int'(rd_addr[13:2]);
        @(posedge clk);
        #5;
        rd_rdy = 1'b0;
        for (int w = 0; w < 4; w++) begin
          stall();  // idle gap before each beat
          ret_valid = 1'b1;
          ret_last  = (w == 3);
          ret_data  = mem[base + w];
          @(posedge clk);
          #5;
          ret_valid = 1'b0;
          ret_last  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int NUM_TESTS      = 40;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 60;
  localparam int RAND_SEED      = 89432;
  localparam logic [1:0] KIND_ANY  = 2'd0;
  localparam logic [1:0] KIND_HIT  = 2'd1;
  localparam logic [1:0] KIND_MISS = 2'd2;

  typedef struct packed {
    dcache_pkg::cpu_req_t req;
    logic [1:0]           kind;  // expected hit or miss, or either
  } stim_t;

  logic                 clk;
  logic                 resetn;
  logic                 valid;
  dcache_pkg::cpu_req_t req;
  logic                 addr_ok;
  logic                 data_ok;
  dcache_pkg::word_t    rdata;
  logic                 rd_req;
  dcache_pkg::addr_t    rd_addr;
  logic                 rd_rdy;
  logic                 ret_valid;
  logic                 ret_last;
  dcache_pkg::word_t    ret_data;
  logic                 wr_req;
  dcache_pkg::addr_t    wr_addr;
  dcache_pkg::line_t    wr_data;
  logic                 wr_rdy;

  stim_t             stim [NUM_TESTS];
  dcache_pkg::word_t shadow [4096];
  int                cycles = 0;

  dcache_top dcache_top_inst (
    .clk, .resetn, .valid, .req, .addr_ok, .data_ok, .rdata, .rd_req, .rd_addr,
    .rd_rdy, .ret_valid, .ret_last, .ret_data, .wr_req, .wr_addr, .wr_data, .wr_rdy
  );

  mem_model mem_inst (
    .clk, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
    .wr_req, .wr_addr, .wr_data, .wr_rdy
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic int word_index(input dcache_pkg::addr_t a);
    return int'(a[13:2]);
  endfunction

  function automatic stim_t make_entry(input int op, input int tag, input int index,
                                       input int offset, input int wstrb,
                                       input logic [31:0] wdata, input logic [1:0] kind);
    stim_t e;
    e.req.op     = 1'(op);
    e.req.tag    = dcache_pkg::tag_t'(tag);
    e.req.index  = dcache_pkg::index_t'(index);
    e.req.offset = dcache_pkg::offset_t'(offset);
    e.req.wstrb  = dcache_pkg::strb_t'(wstrb);
    e.req.wdata  = wdata;
    e.kind       = kind;
    return e;
  endfunction

  task automatic fill_table();
    stim[0]  = make_entry(0, 0, 0, 4, 0, 32'h0, KIND_MISS);  // never-touched line
    stim[1]  = make_entry(0, 0, 0, 4, 0, 32'h0, KIND_HIT);
    stim[2]  = make_entry(1, 0, 0, 4, 4'b0101, 32'h1122_3344, KIND_HIT);
    stim[3]  = make_entry(0, 0, 0, 4, 0, 32'h0, KIND_HIT);
    stim[4]  = make_entry(1, 1, 1, 8, 4'b1100, 32'hDEAD_BEEF, KIND_MISS);  // store miss
    stim[5]  = make_entry(0, 1, 1, 8, 0, 32'h0, KIND_HIT);
    stim[6]  = make_entry(1, 1, 0, 0, 4'b1111, 32'h0BAD_F00D, KIND_MISS);
    stim[7]  = make_entry(1, 2, 0, 12, 4'b0011, 32'hCAFE_5A5A, KIND_MISS);  // dirty victim
    stim[8]  = make_entry(0, 0, 0, 4, 0, 32'h0, KIND_ANY);
    stim[9]  = make_entry(0, 1, 0, 0, 0, 32'h0, KIND_ANY);
    stim[10] = make_entry(0, 2, 0, 12, 0, 32'h0, KIND_ANY);
    for (int i = 11; i < NUM_TESTS; i++) begin
      stim[i] = make_entry(int'($urandom % 2), int'($urandom % 4), int'($urandom % 2),
                           int'($urandom % 4) * 4, int'($urandom % 16), $urandom, KIND_ANY);
    end
  endtask

  task automatic run_access(input int idx);
    dcache_pkg::cpu_req_t r;
    dcache_pkg::addr_t    line_addr;
    dcache_pkg::word_t    expect_word;
    int                   widx;
    int                   lat;
    logic                 saw_rd;
    r         = stim[idx].req;
    line_addr = {r.tag, r.index, dcache_pkg::offset_t'(0)};
    widx      = word_index({r.tag, r.index, r.offset});
    valid     = 1'b1;
    req       = r;
    @(negedge clk);
    while (!addr_ok) @(negedge clk);
    @(posedge clk);  // accepting edge
    #5;
    valid  = 1'b0;
    lat    = 0;
    saw_rd = 1'b0;
    do begin
      @(negedge clk);
      lat++;
      if (rd_req) begin
        saw_rd = 1'b1;
        assert (rd_addr == line_addr) else stop_on_error($sformatf(
          "Mismatch rd_addr entry %0d: got %h expected %h", idx, rd_addr, line_addr));
      end
      // victim line sits in the same set under another tag
      if (wr_req) begin
        assert (wr_addr[3:0] == 4'h0 && wr_addr[11:4] == r.index && wr_addr[31:12] != r.tag)
        else stop_on_error($sformatf(
          "Mismatch wr_addr entry %0d: got %h expected set %h with a tag other than %h",
          idx, wr_addr, r.index, r.tag));
      end
    end while (!data_ok);
    expect_word = shadow[widx];
    if (r.op) begin
      for (int b = 0; b < 4; b++) begin
        if (r.wstrb[b]) shadow[widx][8*b +: 8] = r.wdata[8*b +: 8];
      end
    end else begin
      assert (rdata == expect_word) else stop_on_error($sformatf(
        "Mismatch rdata entry %0d: got %h expected %h", idx, rdata, expect_word));
    end
    if (stim[idx].kind == KIND_HIT) begin
      assert (lat == 1 && !saw_rd) else stop_on_error($sformatf(
        "entry %0d should hit but took %0d cycles or asked for a refill", idx, lat));
    end else if (stim[idx].kind == KIND_MISS) begin
      assert (saw_rd) else stop_on_error($sformatf(
        "entry %0d should miss but the cache never asked for a refill", idx));
    end
    @(posedge clk);
    #5;
  endtask

  // every write-back must carry the latest stored data of its line
  always @(negedge clk) begin
    if (wr_req && wr_rdy) begin
      for (int w = 0; w < 4; w++) begin
        assert (wr_data[32*w +: 32] == shadow[word_index(wr_addr) + w])
        else stop_on_error($sformatf("Mismatch wr_data word %0d at %h: got %h expected %h",
          w, wr_addr, wr_data[32*w +: 32], shadow[word_index(wr_addr) + w]));
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout after %0d cycles, the cache stopped answering",
                              TIMEOUT_CYCLES));
    end
  end

  initial begin
    void'($urandom(RAND_SEED));
    resetn = 1'b0;
    valid  = 1'b0;
    req    = '0;
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = (i * 4) ^ 32'hA5A5_0000;
    end
    fill_table();
    repeat (2) @(posedge clk);
    #5;
    resetn = 1'b1;
    @(negedge clk);
    assert (addr_ok && !data_ok && !rd_req && !wr_req) else stop_on_error($sformatf(
      "Mismatch idle outputs: addr_ok=%h data_ok=%h rd_req=%h wr_req=%h expected 1 0 0 0",
      addr_ok, data_ok, rd_req, wr_req));
    @(posedge clk);
    #5;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_access(i);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/dcache_pkg.sv
design/tagv_array.sv
design/data_way.sv
design/victim_lfsr.sv
design/cache_ctrl.sv
design/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
